// File: Bender.yml
package:
  name: mem_bus_ctl

export_include_dirs:
  - include

sources:
  - logic/mboxPkg.sv
  - logic/phaseClock.sv
  - logic/memStartCtl.sv
  - logic/requestHold.sv
  - logic/coreReadSeq.sv
  - logic/memBusCtl.sv
  - target: test
    files:
      - verification/memBusChecker.sv
      - verification/memBusTb.sv

// File: include/mbox_cfg.svh
// Sizes are fixed for a four-word block; the RTL does not support other values.
`ifndef MBOX_CFG_SVH
`define MBOX_CFG_SVH

// Words moved by one memory request.
// Each word has its own bit in the request mask.
`define MBOX_WORDS 4

// Width of the word address inside a block.
// It must cover MBOX_WORDS words.
`define MBOX_ADR_BITS 2

// Clock cycles in one controller phase.
// A full A/B phase pair is twice this long.
`define MBOX_PHASE_LEN 4

// Phase pairs a start may stay active before the watchdog assertion fires.
// It bounds the slowest expected controller.
`define MBOX_WATCH_START 8

`endif

// File: logic/coreReadSeq.sv
// Data-valid strobes count only during a core read; rdInProg drops the edge after the last word.
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module coreReadSeq (
  input  logic             clk,
  input  logic             rst,
  input  logic             memStartA,
  input  logic             memStartB,
  input  logic             memRdRq,
  input  mboxPkg::wordMask memRq,
  input  mboxPkg::wordAdr  memAdr,
  input  logic             aChangeComing,
  input  logic             bChangeComing,
  input  logic             dataValidA,
  input  logic             dataValidB,
  input  logic             nxmDataVal,
  output logic             coreDataValid,
  output mboxPkg::wordAdr  coreAdr,
  output logic             coreRdInProg
);

  typedef logic [$clog2(`MBOX_WORDS + 1)-1:0] wordCount;

  logic     startActive;
  logic     startSeen;
  logic     readStart;
  logic     dvMinus2;
  logic     dvMinus1;
  wordCount rqWords;
  wordCount wordsLeft;

  assign startActive = memStartA | memStartB;
  assign readStart   = startActive & ~startSeen & memRdRq;

  // Number of words the read will deliver.
  always_comb begin
    rqWords = '0;
    for (int i = 0; i < `MBOX_WORDS; i++) begin
      rqWords = rqWords + wordCount'(memRq[i]);
    end
  end

  // Data may still arrive after the start has been released, so gate on the read itself.
  assign dvMinus2 = coreRdInProg &
                    ((aChangeComing & (dataValidA | nxmDataVal)) |
                     (bChangeComing & (dataValidB | nxmDataVal)));

  always_ff @(posedge clk) begin
    if (rst) begin
      startSeen     <= 1'b0;
      dvMinus1      <= 1'b0;
      coreDataValid <= 1'b0;
      coreRdInProg  <= 1'b0;
      wordsLeft     <= '0;
    end else begin
      startSeen     <= startActive;
      dvMinus1      <= dvMinus2;
      coreDataValid <= dvMinus1;
      if (readStart) begin
        coreRdInProg <= 1'b1;
        wordsLeft    <= rqWords;
      end else if (coreDataValid && coreRdInProg) begin
        wordsLeft <= wordsLeft - 1'b1;
        if (wordsLeft == wordCount'(1)) begin
          coreRdInProg <= 1'b0;
        end
      end
    end
  end

  // coreAdr names the word of the current pulse and wraps within the block.
  always_ff @(posedge clk) begin
    if (readStart) begin
      coreAdr <= memAdr;
    end else if (coreDataValid) begin
      coreAdr <= coreAdr + 1'b1;
    end
  end

endmodule

// File: logic/mboxPkg.sv
// Shared types for the memory request path; widths follow mbox_cfg.svh.
`include "mbox_cfg.svh"

package mboxPkg;

  // One bit per requested word.
  // Bit 0 is the first word of the block.
  typedef logic [`MBOX_WORDS-1:0] wordMask;

  // Word address within a block.
  typedef logic [`MBOX_ADR_BITS-1:0] wordAdr;

  // Cycle count inside one phase.
  typedef logic [$clog2(`MBOX_PHASE_LEN)-1:0] phaseCount;

  // Owner of the current phase.
  typedef enum logic {
    phaseA = 1'b0,
    phaseB = 1'b1
  } phaseSel;

endpackage

// File: logic/memBusCtl.sv
// Top level of the memory request sequencer; one requester and two controllers, A and B.
`timescale 1ns/10ps

module memBusCtl (
  input  logic             clk,
  input  logic             rst,
  input  logic             startReq,
  input  mboxPkg::wordMask rqIn,
  input  logic             rdReqIn,
  input  logic             wrReqIn,
  input  mboxPkg::wordAdr  sbusAdr,
  input  logic             adrPar,
  input  logic             wrBadAdrPar,
  input  logic             acknA,
  input  logic             acknB,
  input  logic             nxmAckn,
  input  logic             dataValidA,
  input  logic             dataValidB,
  input  logic             nxmDataVal,
  output logic             aChangeComing,
  output logic             bChangeComing,
  output logic             phaseChangeComing,
  output logic             memStartA,
  output logic             memStartB,
  output logic             acknPulse,
  output mboxPkg::wordMask memRq,
  output logic             memRdRq,
  output logic             memWrRq,
  output mboxPkg::wordAdr  memAdr,
  output logic             memAdrPar,
  output logic             coreDataValid,
  output mboxPkg::wordAdr  coreAdr,
  output logic             coreRdInProg
);

  logic forceBadPar;

  phaseClock phaseClock0 (
    .clk               (clk),
    .rst               (rst),
    .aChangeComing     (aChangeComing),
    .bChangeComing     (bChangeComing),
    .phaseChangeComing (phaseChangeComing)
  );

  memStartCtl memStartCtl0 (
    .clk           (clk),
    .rst           (rst),
    .startReq      (startReq),
    .aChangeComing (aChangeComing),
    .bChangeComing (bChangeComing),
    .acknA         (acknA),
    .acknB         (acknB),
    .nxmAckn       (nxmAckn),
    .wrBadAdrPar   (wrBadAdrPar),
    .memRq         (memRq),
    .memStartA     (memStartA),
    .memStartB     (memStartB),
    .acknPulse     (acknPulse),
    .forceBadPar   (forceBadPar)
  );

  requestHold requestHold0 (
    .clk         (clk),
    .rst         (rst),
    .memStartA   (memStartA),
    .memStartB   (memStartB),
    .rqIn        (rqIn),
    .rdReqIn     (rdReqIn),
    .wrReqIn     (wrReqIn),
    .sbusAdr     (sbusAdr),
    .adrPar      (adrPar),
    .forceBadPar (forceBadPar),
    .memRq       (memRq),
    .memRdRq     (memRdRq),
    .memWrRq     (memWrRq),
    .memAdr      (memAdr),
    .memAdrPar   (memAdrPar)
  );

  coreReadSeq coreReadSeq0 (
    .clk           (clk),
    .rst           (rst),
    .memStartA     (memStartA),
    .memStartB     (memStartB),
    .memRdRq       (memRdRq),
    .memRq         (memRq),
    .memAdr        (memAdr),
    .aChangeComing (aChangeComing),
    .bChangeComing (bChangeComing),
    .dataValidA    (dataValidA),
    .dataValidB    (dataValidB),
    .nxmDataVal    (nxmDataVal),
    .coreDataValid (coreDataValid),
    .coreAdr       (coreAdr),
    .coreRdInProg  (coreRdInProg)
  );

endmodule

// File: logic/memStartCtl.sv
// A zero request mask is never released; the requester must hold startReq until granted.
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module memStartCtl (
  input  logic             clk,
  input  logic             rst,
  input  logic             startReq,
  input  logic             aChangeComing,
  input  logic             bChangeComing,
  input  logic             acknA,
  input  logic             acknB,
  input  logic             nxmAckn,
  input  logic             wrBadAdrPar,
  input  mboxPkg::wordMask memRq,
  output logic             memStartA,
  output logic             memStartB,
  output logic             acknPulse,
  output logic             forceBadPar
);

  localparam int watchCycles = `MBOX_WATCH_START * 2 * `MBOX_PHASE_LEN;

  logic             startActive;
  logic             acknForA;
  logic             acknForB;
  logic             lastAckn;
  mboxPkg::wordMask rqDone;
  mboxPkg::wordMask rqLeft;
  mboxPkg::wordMask lowestLeft;

  assign startActive = memStartA | memStartB;

  // An acknowledge only counts on the strobe of the controller that owns the start.
  assign acknForA  = memStartA & aChangeComing & (acknA | nxmAckn);
  assign acknForB  = memStartB & bChangeComing & (acknB | nxmAckn);
  assign acknPulse = acknForA | acknForB;

  // Words still waiting for an acknowledge.
  // memRq is frozen by requestHold for as long as the start is up.
  assign rqLeft     = memRq & ~rqDone;
  assign lowestLeft = rqLeft & (~rqLeft + mboxPkg::wordMask'(1));
  assign lastAckn   = acknPulse && ((rqLeft & ~lowestLeft) == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      memStartA <= 1'b0;
      memStartB <= 1'b0;
    end else if (startActive) begin
      if (lastAckn) begin
        memStartA <= 1'b0;
        memStartB <= 1'b0;
      end
    end else begin
      // The grant goes to whichever controller's turn is about to begin.
      memStartA <= startReq & aChangeComing;
      memStartB <= startReq & bChangeComing;
    end
  end

  // Each counted acknowledge retires the lowest word still outstanding.
  always_ff @(posedge clk) begin
    if (rst || !startActive) begin
      rqDone <= '0;
    end else if (acknPulse) begin
      rqDone <= rqDone | lowestLeft;
    end
  end

  // Bad parity is armed between starts and lasts for exactly one start.
  always_ff @(posedge clk) begin
    if (rst) begin
      forceBadPar <= 1'b0;
    end else if (!startActive && wrBadAdrPar) begin
      forceBadPar <= 1'b1;
    end else if (lastAckn) begin
      forceBadPar <= 1'b0;
    end
  end

  startOneHot: assert property (
    @(posedge clk) disable iff (rst) !(memStartA && memStartB)
  ) else $error("memStartA and memStartB active together");

  // A controller that never sends its last acknowledge would hang the request path.
  startWatch: assert property (
    @(posedge clk) disable iff (rst) $rose(startActive) |-> ##[1:watchCycles] !startActive
  ) else $error("start active longer than %0d cycles", watchCycles);

endmodule

// File: logic/phaseClock.sv
// The first A phase starts one cycle after rst is released; strobes are low until then.
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module phaseClock (
  input  logic clk,
  input  logic rst,
  output logic aChangeComing,
  output logic bChangeComing,
  output logic phaseChangeComing
);

  localparam mboxPkg::phaseCount lastCount = mboxPkg::phaseCount'(`MBOX_PHASE_LEN - 1);

  mboxPkg::phaseSel phase;
  mboxPkg::phaseCount count;

  // Reset parks the counter on the last cycle of a B phase.
  // The first edge after reset then opens phase A.
  always_ff @(posedge clk) begin
    if (rst) begin
      phase             <= mboxPkg::phaseB;
      count             <= lastCount;
      aChangeComing     <= 1'b0;
      bChangeComing     <= 1'b0;
      phaseChangeComing <= 1'b0;
    end else begin
      if (count == lastCount) begin
        count <= '0;
        phase <= (phase == mboxPkg::phaseA) ? mboxPkg::phaseB : mboxPkg::phaseA;
      end else begin
        count <= count + 1'b1;
      end
      // Strobes are decoded one cycle early so that each comes straight from a flop.
      aChangeComing     <= (count == lastCount) && (phase == mboxPkg::phaseB);
      bChangeComing     <= (count == lastCount) && (phase == mboxPkg::phaseA);
      phaseChangeComing <= (count == lastCount - 1'b1);
    end
  end

  // Start grants and acknowledge counting in memStartCtl rely on strobes that alternate.
  strobeAlternate: assert property (
    @(posedge clk) disable iff (rst)
    aChangeComing |-> ##(`MBOX_PHASE_LEN) (bChangeComing && !aChangeComing)
  ) else $error("bChangeComing did not follow aChangeComing one phase later");

endmodule

// File: logic/requestHold.sv
// Request fields follow the inputs every cycle while idle; memAdr and parity have no reset.
`timescale 1ns/10ps

module requestHold (
  input  logic             clk,
  input  logic             rst,
  input  logic             memStartA,
  input  logic             memStartB,
  input  mboxPkg::wordMask rqIn,
  input  logic             rdReqIn,
  input  logic             wrReqIn,
  input  mboxPkg::wordAdr  sbusAdr,
  input  logic             adrPar,
  input  logic             forceBadPar,
  output mboxPkg::wordMask memRq,
  output logic             memRdRq,
  output logic             memWrRq,
  output mboxPkg::wordAdr  memAdr,
  output logic             memAdrPar
);

  logic rqHold;
  logic adrParHold;

  // The request is frozen from the edge that raises a start until that start falls.
  assign rqHold = memStartA | memStartB;

  always_ff @(posedge clk) begin
    if (rst) begin
      memRq   <= '0;
      memRdRq <= 1'b0;
      memWrRq <= 1'b0;
    end else if (!rqHold) begin
      memRq   <= rqIn;
      memRdRq <= rdReqIn;
      memWrRq <= wrReqIn;
    end
  end

  always_ff @(posedge clk) begin
    if (!rqHold) begin
      memAdr     <= sbusAdr;
      adrParHold <= adrPar;
    end
  end

  // Parity covers the incoming address parity, both flags, the mask and the word address.
  // A forced error flips the result for one whole start.
  assign memAdrPar = adrParHold ^
                     memRdRq ^
                     memWrRq ^
                     (^memRq) ^
                     (^memAdr) ^
                     forceBadPar;

  // A start with an empty mask never sees its last acknowledge in memStartCtl.
  rqNotEmpty: assert property (
    @(posedge clk) disable iff (rst) rqHold |-> (memRq != '0)
  ) else $error("start active with an empty request mask");

endmodule

// File: tb.f
+incdir+include
logic/mboxPkg.sv
logic/phaseClock.sv
logic/memStartCtl.sv
logic/requestHold.sv
logic/coreReadSeq.sv
logic/memBusCtl.sv
verification/memBusChecker.sv
verification/memBusTb.sv

// File: verification/memBusChecker.sv
// Reference model for memBusCtl; samples every rising edge and assumes the four-word block config.
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module memBusChecker (
  input  logic             clk,
  input  logic             rst,
  input  logic             startReq, rdReqIn, wrReqIn, adrPar, wrBadAdrPar,
  input  logic             acknA, acknB, nxmAckn, dataValidA, dataValidB, nxmDataVal,
  input  mboxPkg::wordMask rqIn, memRq,
  input  mboxPkg::wordAdr  sbusAdr, memAdr, coreAdr,
  input  logic             aChangeComing, bChangeComing, phaseChangeComing,
  input  logic             memStartA, memStartB, acknPulse, memRdRq, memWrRq, memAdrPar,
  input  logic             coreDataValid, coreRdInProg,
  output int               checks,
  output int               mismatches
);

  int               cyc;
  int               ackLeft;
  int               rdLeft;
  logic             expA, expB, expForce, wasActive, rdBusy;
  logic             heldRd, heldWr, heldPar;
  logic [1:0]       dvPipe;
  mboxPkg::wordMask heldRq;
  mboxPkg::wordAdr  heldAdr, expCoreAdr;

  function automatic int countWords(mboxPkg::wordMask m);
    int n;
    n = 0;
    for (int i = 0; i < `MBOX_WORDS; i++)
      n += m[i];
    return n;
  endfunction

  task automatic compare(string name, logic [7:0] expVal, logic [7:0] actVal);
    checks++;
    if (actVal !== expVal) begin
      mismatches++;
      $display("mismatch %s at %0t: expected %h actual %h", name, $time, expVal, actVal);
    end
  endtask

  always @(posedge clk) begin : model
    int   pos;
    logic aExp, bExp, active, ackExp, lastAck, dvIn, readStart;
    if (rst) begin
      cyc = 0;
      checks = 0;
      mismatches = 0;
      expA = 1'b0;
      expB = 1'b0;
      expForce = 1'b0;
      wasActive = 1'b0;
      rdBusy = 1'b0;
      dvPipe = 2'b00;
      heldRq = '0;
      heldRd = 1'b0;
      heldWr = 1'b0;
      heldAdr = sbusAdr;
      heldPar = adrPar;
    end else begin
      // The first A strobe shows one cycle after reset, then one strobe per phase.
      pos = (cyc - 1) % (2 * `MBOX_PHASE_LEN);
      aExp = (cyc >= 1) && (pos == 0);
      bExp = (cyc >= 1) && (pos == `MBOX_PHASE_LEN);
      active = expA | expB;
      ackExp = (expA & aExp & (acknA | nxmAckn)) | (expB & bExp & (acknB | nxmAckn));
      lastAck = ackExp && (ackLeft == 1);
      dvIn = rdBusy & ((aExp & (dataValidA | nxmDataVal)) | (bExp & (dataValidB | nxmDataVal)));
      readStart = active & ~wasActive & heldRd;

      compare(cyc == 0 ? "resetState" : "phaseStrobe",
              {aExp, bExp, (cyc >= 1) && (pos % `MBOX_PHASE_LEN == `MBOX_PHASE_LEN - 1)},
              {aChangeComing, bChangeComing, phaseChangeComing});
      compare(cyc == 0 ? "resetState" : "startGrant", {expA, expB}, {memStartA, memStartB});
      compare("acknRelease", ackExp, acknPulse);
      compare("requestHold", {heldRq, heldRd, heldWr, heldAdr},
              {memRq, memRdRq, memWrRq, memAdr});
      compare("parity", heldPar ^ heldRd ^ heldWr ^ (^heldRq) ^ (^heldAdr) ^ expForce, memAdrPar);
      compare("coreRead", {dvPipe[1], rdBusy}, {coreDataValid, coreRdInProg});
      if (dvPipe[1])
        compare("coreAdr", expCoreAdr, coreAdr);

      if (readStart) begin
        rdBusy = 1'b1;
        rdLeft = countWords(heldRq);
        expCoreAdr = heldAdr;
      end else if (dvPipe[1]) begin
        expCoreAdr = expCoreAdr + 1'b1;
        if (rdBusy) begin
          rdLeft--;
          rdBusy = (rdLeft != 0);
        end
      end
      dvPipe = {dvPipe[0], dvIn};
      wasActive = active;

      if (active) begin
        if (ackExp)
          ackLeft--;
        if (lastAck) begin
          expA = 1'b0;
          expB = 1'b0;
          expForce = 1'b0;
        end
      end else begin
        expA = startReq & aExp;
        expB = startReq & bExp;
        if (wrBadAdrPar)
          expForce = 1'b1;
        heldRq = rqIn;
        heldRd = rdReqIn;
        heldWr = wrReqIn;
        heldAdr = sbusAdr;
        heldPar = adrPar;
        ackLeft = countWords(rqIn);
      end
      cyc++;
    end
  end

endmodule

// File: verification/memBusTb.sv
// Testbench for memBusCtl; one requester and a responder that plays both memory controllers.
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module memBusTb;

  localparam int  numRequests = 200;
  localparam real watchdogNs = 1.0 * numRequests * `MBOX_WATCH_START * 2 * `MBOX_PHASE_LEN * 4;

  logic             clk, rst, startReq, rdReqIn, wrReqIn, adrPar, wrBadAdrPar;
  logic             acknA, acknB, nxmAckn, dataValidA, dataValidB, nxmDataVal;
  logic             aChangeComing, bChangeComing, phaseChangeComing;
  logic             memStartA, memStartB, acknPulse, memRdRq, memWrRq, memAdrPar;
  logic             coreDataValid, coreRdInProg;
  mboxPkg::wordMask rqIn, memRq;
  mboxPkg::wordAdr  sbusAdr, memAdr, coreAdr;
  int               checks, mismatches;
  int               skips = 0;
  logic             ownerStrobe, doAckn, nxmPath;

  memBusCtl dut0 (.*);
  memBusChecker check0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Worst case allows every request its full start watch window.
  initial begin
    #(watchdogNs + 40.0);
    $display("Timeout: run did not finish, %0d mismatches in %0d checks", mismatches, checks);
    $display("Finished with errors");
    $finish;
  end

  task automatic nextCycle();
    @(negedge clk);
    wrBadAdrPar = ($urandom % 16) == 0;
  endtask

  task automatic randomRequest();
    rqIn    = mboxPkg::wordMask'($urandom % 15 + 1);
    rdReqIn = 1'($urandom);
    wrReqIn = 1'($urandom);
    sbusAdr = mboxPkg::wordAdr'($urandom);
    adrPar  = 1'($urandom);
  endtask

  // Responder. Acks and data-valid on strobes it does not own are noise.
  always @(negedge clk) begin
    if (!rst) begin
      ownerStrobe = (memStartA & aChangeComing) | (memStartB & bChangeComing);
      nxmPath = ($urandom % 4) == 0;
      if (!(memStartA | memStartB))
        skips = 0;
      {acknA, acknB, nxmAckn} = 3'($urandom);
      {dataValidA, dataValidB, nxmDataVal} = 3'($urandom);
      if (ownerStrobe) begin
        // At most three skipped phases keep a start inside the watch window.
        doAckn = (skips >= 3) || (($urandom % 4) != 0);
        if (!doAckn)
          skips++;
        acknA      = memStartA & doAckn & ~nxmPath;
        acknB      = memStartB & doAckn & ~nxmPath;
        nxmAckn    = doAckn & nxmPath;
        dataValidA = memStartA & doAckn & memRdRq & ~nxmPath;
        dataValidB = memStartB & doAckn & memRdRq & ~nxmPath;
        nxmDataVal = doAckn & memRdRq & nxmPath;
      end
    end
  end

  initial begin
    void'($urandom(32'h76d2_9165));
    rst = 1'b1;
    startReq = 1'b0;
    wrBadAdrPar = 1'b0;
    acknA = 1'b0;
    acknB = 1'b0;
    nxmAckn = 1'b0;
    dataValidA = 1'b0;
    dataValidB = 1'b0;
    nxmDataVal = 1'b0;
    randomRequest();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < numRequests; n++) begin
      repeat ($urandom % 8)
        nextCycle();
      randomRequest();
      startReq = 1'b1;
      do
        nextCycle();
      while (!(memStartA | memStartB));
      startReq = 1'b0;
      // Inputs keep moving while the start holds the request.
      while (memStartA | memStartB) begin
        randomRequest();
        nextCycle();
      end
    end
    repeat (16)
      nextCycle();
    $display("Run complete: %0d checks, %0d mismatches", checks, mismatches);
    if (mismatches == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
